//--- Makefile
TOP = scoreboard_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f scoreboard.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f scoreboard.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- hw/ready_bit_ram.sv
`timescale 1ns/1ps

module ready_bit_ram (
   input  logic                   CLK,
   input  logic                   we,              // Write strobe from arbiter
   input  sb_bus_pkg::wr_req_t    wr,              // Register and value to store
   input  sb_geom_pkg::preg_vec_t rd_addr,         // Seven lookup addresses
   output sb_geom_pkg::rdy_vec_t  rd_data          // Seven ready bits, async
);

   import sb_geom_pkg::*;

   // Distributed RAM model, contents undefined until the init sweep
   logic ram [NUM_PREGS];

   // Asynchronous read ports
   always_comb begin
      for (int i = 0; i < NUM_RD; i++) begin
         rd_data[i] = ram[rd_addr[i]];             // One LUT read per port
      end
   end

   // Single synchronous write port
   always_ff @(posedge CLK) begin
      if (we) begin
         ram[wr.preg] <= wr.val;                   // Visible to reads after the edge
      end
   end

endmodule

//--- hw/ready_lookup.sv
`timescale 1ns/1ps

module ready_lookup (
   input  logic                   CLK,
   input  logic                   arst_n,
   input  sb_geom_pkg::rdy_vec_t  tbl_data,        // Async table read results
   input  sb_geom_pkg::preg_vec_t rd_addr,         // Lookup addresses from rename
   input  logic                   we,              // Write committed at this edge
   input  sb_bus_pkg::wr_req_t    wr,              // That write's register and value
   output sb_geom_pkg::rdy_vec_t  rdy              // Registered lookup results
);

   import sb_geom_pkg::*;

   rdy_vec_t hit;                                  // Port address matches the write
   rdy_vec_t rdy_d;                                // Next result per port

   // Same-edge bypass, the table only shows the write after this edge
   always_comb begin
      for (int i = 0; i < NUM_RD; i++) begin
         hit[i]   = we && (rd_addr[i] == wr.preg);
         rdy_d[i] = hit[i] ? wr.val : tbl_data[i];
      end
   end

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         rdy <= '0;                                // Nothing ready until sampled
      end else begin
         rdy <= rdy_d;                             // Latency one from address
      end
   end

endmodule

//--- hw/sb_bus_pkg.sv
package sb_bus_pkg;

   // Write-bus clients sharing the single table write port
   localparam int NUM_CLIENTS = 3;

   typedef logic [1:0] client_t;                    // Client index

   localparam client_t CL_INIT  = 2'd0;             // Post-reset table sweep
   localparam client_t CL_ALLOC = 2'd1;             // Rename allocation, clears
   localparam client_t CL_WB    = 2'd2;             // Writeback, sets

   // One write as a client presents it, held stable while req is high
   typedef struct packed {
      sb_geom_pkg::preg_t preg;                     // Target physical register
      logic               val;                      // Ready value to store
   } wr_req_t;

   // Arbiter mode: init sweep only, then normal round-robin
   typedef enum logic {
      INIT_PHASE,
      RUN
   } arb_state_t;

endpackage

//--- hw/sb_geom_pkg.sv
package sb_geom_pkg;

   // Physical register file geometry
   localparam int PREG_BITS = 6;                    // Register index width
   localparam int NUM_PREGS = 1 << PREG_BITS;       // Table depth, 64 entries
   localparam int NUM_RD    = 7;                    // Rename-stage lookup ports

   // Names one physical register
   typedef logic [PREG_BITS-1:0] preg_t;

   // All lookup addresses in one vector, port 0 in the low bits
   typedef preg_t [NUM_RD-1:0] preg_vec_t;

   // One ready bit per lookup port
   typedef logic [NUM_RD-1:0] rdy_vec_t;

endpackage

//--- hw/scoreboard_top.sv
`timescale 1ns/1ps

module scoreboard_top (
   input  logic                   CLK,
   input  logic                   arst_n,
   input  logic                   alloc_req,       // Allocation client, clears
   input  sb_bus_pkg::wr_req_t    alloc_wr,
   output logic                   alloc_ack,
   input  logic                   wb_req,          // Writeback client, sets
   input  sb_bus_pkg::wr_req_t    wb_wr,
   output logic                   wb_ack,
   input  sb_geom_pkg::preg_vec_t rd_addr,         // Seven rename lookups
   output sb_geom_pkg::rdy_vec_t  rdy,
   output logic                   tbl_ready        // Sweep complete
);

   import sb_geom_pkg::*;
   import sb_bus_pkg::*;

   logic                   init_req;
   wr_req_t                init_wr;
   logic [NUM_CLIENTS-1:0] req_vec;                // Indexed by client_t
   wr_req_t [NUM_CLIENTS-1:0] wr_vec;
   logic [NUM_CLIENTS-1:0] ack_vec;
   logic                   tbl_we;                 // Arbiter write to table
   wr_req_t                tbl_wr;
   rdy_vec_t               tbl_data;               // Async table outputs

   assign req_vec[CL_INIT]  = init_req;
   assign req_vec[CL_ALLOC] = alloc_req;
   assign req_vec[CL_WB]    = wb_req;
   assign wr_vec[CL_INIT]   = init_wr;
   assign wr_vec[CL_ALLOC]  = alloc_wr;
   assign wr_vec[CL_WB]     = wb_wr;
   assign alloc_ack         = ack_vec[CL_ALLOC];
   assign wb_ack            = ack_vec[CL_WB];

   table_init u_init (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .req       (init_req),
      .wr        (init_wr),
      .ack       (ack_vec[CL_INIT]),
      .tbl_ready (tbl_ready)
   );

   write_arbiter u_arb (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .tbl_ready (tbl_ready),
      .req       (req_vec),
      .wr_in     (wr_vec),
      .ack       (ack_vec),
      .we        (tbl_we),
      .wr        (tbl_wr)
   );

   ready_bit_ram u_ram (
      .CLK       (CLK),
      .we        (tbl_we),
      .wr        (tbl_wr),
      .rd_addr   (rd_addr),
      .rd_data   (tbl_data)
   );

   ready_lookup u_lookup (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .tbl_data  (tbl_data),
      .rd_addr   (rd_addr),
      .we        (tbl_we),
      .wr        (tbl_wr),
      .rdy       (rdy)
   );

endmodule

//--- hw/table_init.sv
`timescale 1ns/1ps

module table_init (
   input  logic                CLK,
   input  logic                arst_n,
   output logic                req,                // Four-phase request
   output sb_bus_pkg::wr_req_t wr,                 // Current sweep write
   input  logic                ack,                // Arbiter acknowledge
   output logic                tbl_ready           // Whole table written
);

   import sb_geom_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,                                     // Just out of reset
      ST_REQ,                                      // req high, waiting for ack
      ST_RELEASE,                                  // req low, waiting for ack to drop
      ST_DONE                                      // Sweep finished
   } init_state_t;

   init_state_t state;
   preg_t       ptr;                               // Register being written

   assign wr.preg = ptr;
   assign wr.val  = 1'b1;                          // Every register starts ready

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         ptr       <= '0;
         req       <= 1'b0;
         tbl_ready <= 1'b0;
      end else begin
         unique case (state)
            ST_IDLE: begin
               req   <= 1'b1;                      // First entry, ack is low after reset
               state <= ST_REQ;
            end
            ST_REQ: begin
               if (ack) begin
                  req   <= 1'b0;                   // Write committed, release
                  state <= ST_RELEASE;
               end
            end
            ST_RELEASE: begin
               if (!ack) begin                     // Handshake closed
                  if (ptr == preg_t'(NUM_PREGS - 1)) begin
                     tbl_ready <= 1'b1;            // Last entry done
                     state     <= ST_DONE;
                  end else begin
                     ptr   <= ptr + 1'b1;          // Next register
                     req   <= 1'b1;
                     state <= ST_REQ;
                  end
               end
            end
            ST_DONE: begin
               state <= ST_DONE;                   // Idle until next reset
            end
         endcase
      end
   end

endmodule

//--- hw/write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter (
   input  logic                                            CLK,
   input  logic                                            arst_n,
   input  logic                                            tbl_ready,
   input  logic                [sb_bus_pkg::NUM_CLIENTS-1:0] req,
   input  sb_bus_pkg::wr_req_t [sb_bus_pkg::NUM_CLIENTS-1:0] wr_in,
   output logic                [sb_bus_pkg::NUM_CLIENTS-1:0] ack,
   output logic                                            we,
   output sb_bus_pkg::wr_req_t                             wr
);

   import sb_bus_pkg::*;

   arb_state_t             state;
   client_t                last;                   // Last served of alloc/wb
   client_t                sel;                    // Client granted this cycle
   logic                   gnt;                    // A grant is made this cycle
   logic [NUM_CLIENTS-1:0] elig;                   // Request pending, not yet acked

   // A client with ack still high is mid-handshake and cannot be served again
   assign elig = req & ~ack;

   // Grant selection, at most one per edge
   always_comb begin
      gnt = 1'b0;
      sel = CL_INIT;
      unique case (state)
         INIT_PHASE: begin
            if (elig[CL_INIT]) begin               // Only the sweep may write
               gnt = 1'b1;
               sel = CL_INIT;
            end
         end
         RUN: begin
            if (elig[CL_ALLOC] && elig[CL_WB]) begin
               gnt = 1'b1;
               sel = (last == CL_ALLOC) ? CL_WB : CL_ALLOC;  // Last served loses tie
            end else if (elig[CL_ALLOC]) begin
               gnt = 1'b1;
               sel = CL_ALLOC;
            end else if (elig[CL_WB]) begin
               gnt = 1'b1;
               sel = CL_WB;
            end
         end
      endcase
   end

   // Table write port, committed on the same edge that raises ack
   assign we = gnt;
   assign wr = wr_in[sel];

   // Mode and round-robin pointer
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state <= INIT_PHASE;
         last  <= CL_WB;                           // Alloc wins the first tie
      end else begin
         if (state == INIT_PHASE && tbl_ready) begin
            state <= RUN;                          // Sweep done, open to rename
         end
         if (gnt && sel != CL_INIT) begin
            last <= sel;
         end
      end
   end

   // Per-client ack flops
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         ack <= '0;
      end else begin
         for (int i = 0; i < NUM_CLIENTS; i++) begin
            if (gnt && sel == client_t'(i)) begin
               ack[i] <= 1'b1;                     // Write committed this edge
            end else if (!req[i]) begin
               ack[i] <= 1'b0;                     // Client released, close handshake
            end
         end
      end
   end

endmodule

//--- scoreboard.f
hw/sb_geom_pkg.sv
hw/sb_bus_pkg.sv
hw/ready_bit_ram.sv
hw/table_init.sv
hw/write_arbiter.sv
hw/ready_lookup.sv
hw/scoreboard_top.sv
tests/scoreboard_checker.sv
tests/scoreboard_monitor.sv
tests/scoreboard_tb.sv

//--- tests/scoreboard_checker.sv
`timescale 1ns/1ps

module scoreboard_checker (
   input  logic                               CLK,
   input  logic                               arst_n,
   input  logic                               tbl_ready,
   input  logic [sb_bus_pkg::NUM_CLIENTS-1:0] req,       // Arbiter request inputs
   input  logic [sb_bus_pkg::NUM_CLIENTS-1:0] ack        // Arbiter ack flops
);

   import sb_bus_pkg::*;

   // One write per edge, so at most one new ack
   a_one_grant: assert property (@(posedge CLK) disable iff (!arst_n)
      $onehot0(ack & ~$past(ack)))
      else $error("More than one ack rose on the same edge");

   // Rename clients stay out until the sweep is done
   a_init_only: assert property (@(posedge CLK) disable iff (!arst_n)
      !tbl_ready |-> !(ack[CL_ALLOC] || ack[CL_WB]))
      else $error("Rename client acknowledged before the table was ready");

   for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_client
      a_ack_rise: assert property (@(posedge CLK) disable iff (!arst_n)
         $rose(ack[i]) |-> $past(req[i]))                 // Grant needs a pending req
         else $error("Client %0d ack rose without a request", i);

      a_ack_fall: assert property (@(posedge CLK) disable iff (!arst_n)
         $fell(req[i]) |=> !ack[i])                       // Handshake closes next edge
         else $error("Client %0d ack did not fall one edge after req", i);
   end

endmodule

//--- tests/scoreboard_monitor.sv
`timescale 1ns/1ps

module scoreboard_monitor (
   input  logic                   CLK,
   input  logic                   arst_n,
   input  logic                   tbl_ready,
   input  logic                   alloc_req,
   input  sb_bus_pkg::wr_req_t    alloc_wr,
   input  logic                   alloc_ack,
   input  logic                   wb_req,
   input  sb_bus_pkg::wr_req_t    wb_wr,
   input  logic                   wb_ack,
   input  sb_geom_pkg::preg_vec_t rd_addr,
   input  sb_geom_pkg::rdy_vec_t  rdy,
   input  int                     test_idx,      // Test now running
   input  logic                   test_end,      // One cycle at the close of a test
   input  int                     exp_alloc,     // Expected allocation acks this test
   input  int                     exp_wb,        // Expected writeback acks this test
   output int                     err_count,
   output int                     check_count
);

   import sb_geom_pkg::*;
   import sb_bus_pkg::*;

   localparam int STUCK_CYCLES = 8;              // Longest fair wait for an ack

   logic [NUM_PREGS-1:0] model;                  // Reference ready bits
   logic                 model_ok;               // Model valid once the sweep is done
   preg_vec_t            addr_s;                 // Addresses sampled at the edge
   wr_req_t              alloc_s;                // Payloads present at the edge
   wr_req_t              wb_s;
   logic                 alloc_ack_q;
   logic                 wb_ack_q;
   logic                 ready_q;
   int                   test_errs;
   int                   test_checks;
   int                   alloc_rises;
   int                   wb_rises;
   int                   alloc_wait;
   int                   wb_wait;

   // Inputs are driven after the edge, so they are settled here
   always @(posedge CLK) begin
      addr_s  <= rd_addr;
      alloc_s <= alloc_wr;
      wb_s    <= wb_wr;
   end

   // DUT outputs are stable mid-cycle
   always @(negedge CLK) begin
      if (!arst_n) begin
         model_ok    = 1'b0;
         ready_q     = 1'b0;
         alloc_ack_q = 1'b0;
         wb_ack_q    = 1'b0;
         err_count   = 0;
         check_count = 0;
         test_errs   = 0;
         test_checks = 0;
         alloc_rises = 0;
         wb_rises    = 0;
         alloc_wait  = 0;
         wb_wait     = 0;
      end else begin
         if (tbl_ready && !ready_q) begin
            model    = '1;                       // Sweep wrote every entry ready
            model_ok = 1'b1;
         end
         if (alloc_ack && !alloc_ack_q) begin
            model[alloc_s.preg] = alloc_s.val;   // Committed on this edge
            alloc_rises++;
         end
         if (wb_ack && !wb_ack_q) begin
            model[wb_s.preg] = wb_s.val;
            wb_rises++;
         end
         if (model_ok) begin
            for (int i = 0; i < NUM_RD; i++) begin
               check_count++;
               test_checks++;
               if (rdy[i] !== model[addr_s[i]]) begin
                  err_count++;
                  test_errs++;
                  $display("CHECK FAILED at %0t: port %0d reg %0d read %b, expected %b",
                           $time, i, addr_s[i], rdy[i], model[addr_s[i]]);
               end
            end
         end
         // Rename requests are held off while the sweep runs
         alloc_wait = (tbl_ready && alloc_req && !alloc_ack) ? alloc_wait + 1 : 0;
         wb_wait    = (tbl_ready && wb_req && !wb_ack) ? wb_wait + 1 : 0;
         if (alloc_wait == STUCK_CYCLES) begin
            err_count++;
            test_errs++;
            $display("At %0t the allocation request waited %0d cycles and got no ack",
                     $time, STUCK_CYCLES);
         end
         if (wb_wait == STUCK_CYCLES) begin
            err_count++;
            test_errs++;
            $display("At %0t the writeback request waited %0d cycles and got no ack",
                     $time, STUCK_CYCLES);
         end
         if (test_end) begin
            if (alloc_rises != exp_alloc) begin
               err_count++;
               test_errs++;
               $display("CHECK FAILED at %0t: test %0d saw %0d allocation acks, expected %0d",
                        $time, test_idx, alloc_rises, exp_alloc);
            end
            if (wb_rises != exp_wb) begin
               err_count++;
               test_errs++;
               $display("CHECK FAILED at %0t: test %0d saw %0d writeback acks, expected %0d",
                        $time, test_idx, wb_rises, exp_wb);
            end
            $display("test %0d done: %0d checks, %0d errors", test_idx, test_checks, test_errs);
            test_errs   = 0;
            test_checks = 0;
            alloc_rises = 0;
            wb_rises    = 0;
         end
         ready_q     = tbl_ready;
         alloc_ack_q = alloc_ack;
         wb_ack_q    = wb_ack;
      end
   end

endmodule

//--- tests/scoreboard_tb.sv
`timescale 1ns/1ps

module scoreboard_tb;

   import sb_geom_pkg::*;
   import sb_bus_pkg::*;

   localparam int          CLK_PERIOD = 40;
   localparam int          IN_DLY     = 2;         // Drive delay after the rising edge
   localparam int          RST_CYCLES = 3;
   localparam int          NUM_TESTS  = 22;
   localparam int          SWEEPS     = 10;        // Seven registers per sweep test
   localparam int          HS_LIMIT   = 12;        // Driver gives up on ack after this
   localparam int          WD_CYCLES  = NUM_PREGS * 4 + NUM_TESTS * 10;
   localparam logic [31:0] SEED       = 32'd89323;

   typedef struct packed {
      logic       a_en;                            // Allocation write enable
      preg_t      a_reg;
      logic       a_val;
      logic       w_en;                            // Writeback write enable
      preg_t      w_reg;
      logic       w_val;
      logic [2:0] hold;                            // Extra cycles req stays up after ack
      preg_vec_t  rd;                              // Seven lookup registers
      logic       rnd;                             // Random lookups and payloads
      logic [1:0] exp_a;                           // Expected allocation acks
      logic [1:0] exp_w;                           // Expected writeback acks
   } test_t;

   logic        CLK;
   logic        arst_n;
   logic        alloc_req;
   wr_req_t     alloc_wr;
   logic        alloc_ack;
   logic        wb_req;
   wr_req_t     wb_wr;
   logic        wb_ack;
   preg_vec_t   rd_addr;
   rdy_vec_t    rdy;
   logic        tbl_ready;
   int          test_idx;
   logic        test_end;
   int          exp_alloc;
   int          exp_wb;
   int          err_count;
   int          check_count;
   logic [31:0] lfsr;
   test_t       tests [NUM_TESTS];

   initial CLK = 1'b0;
   always #(CLK_PERIOD / 2) CLK = ~CLK;

   scoreboard_top UUT (
      .CLK(CLK), .arst_n(arst_n),
      .alloc_req(alloc_req), .alloc_wr(alloc_wr), .alloc_ack(alloc_ack),
      .wb_req(wb_req), .wb_wr(wb_wr), .wb_ack(wb_ack),
      .rd_addr(rd_addr), .rdy(rdy), .tbl_ready(tbl_ready)
   );

   scoreboard_monitor mon (
      .CLK(CLK), .arst_n(arst_n), .tbl_ready(tbl_ready),
      .alloc_req(alloc_req), .alloc_wr(alloc_wr), .alloc_ack(alloc_ack),
      .wb_req(wb_req), .wb_wr(wb_wr), .wb_ack(wb_ack),
      .rd_addr(rd_addr), .rdy(rdy), .test_idx(test_idx), .test_end(test_end),
      .exp_alloc(exp_alloc), .exp_wb(exp_wb),
      .err_count(err_count), .check_count(check_count)
   );

   bind write_arbiter scoreboard_checker u_checker (
      .CLK(CLK), .arst_n(arst_n), .tbl_ready(tbl_ready), .req(req), .ack(ack)
   );

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_bit(output logic b);
      b    = lfsr[0];
      lfsr = lfsr_step(lfsr);                      // One step per bit taken
   endtask

   task automatic take_reg(output preg_t r);
      logic b;
      r = '0;
      for (int i = 0; i < PREG_BITS; i++) begin
         take_bit(b);
         r = {r[PREG_BITS-2:0], b};
      end
   endtask

   // Port 0 in the low bits
   function automatic preg_vec_t lanes(input preg_t p0, input preg_t p1, input preg_t p2,
                                       input preg_t p3, input preg_t p4, input preg_t p5,
                                       input preg_t p6);
      lanes = {p6, p5, p4, p3, p2, p1, p0};
   endfunction

   function automatic preg_vec_t sweep_lanes(input int s);
      preg_vec_t v;
      for (int i = 0; i < NUM_RD; i++) begin
         v[i] = preg_t'((s * NUM_RD + i) % NUM_PREGS);  // Wraps on the last sweep
      end
      sweep_lanes = v;
   endfunction

   task automatic build_table();
      for (int s = 0; s < SWEEPS; s++) begin
         tests[s] = '{1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 3'd0, sweep_lanes(s),
                      1'b0, 2'd0, 2'd0};
      end
      tests[0].exp_w = 2'd1;                       // Writeback held off by the sweep
      tests[10] = '{1'b1, 6'd5, 1'b0, 1'b0, 6'd0, 1'b0, 3'd0,         // Clear one
                    lanes(6'd5, 6'd5, 6'd6, 6'd4, 6'd5, 6'd0, 6'd63), 1'b0, 2'd1, 2'd0};
      tests[11] = '{1'b0, 6'd0, 1'b0, 1'b1, 6'd5, 1'b1, 3'd0,         // Set it again
                    lanes(6'd5, 6'd4, 6'd5, 6'd6, 6'd5, 6'd5, 6'd5), 1'b0, 2'd0, 2'd1};
      tests[12] = '{1'b1, 6'd12, 1'b0, 1'b1, 6'd41, 1'b1, 3'd0,       // Contention
                    lanes(6'd12, 6'd41, 6'd12, 6'd41, 6'd11, 6'd40, 6'd0), 1'b0, 2'd1, 2'd1};
      tests[13] = '{1'b1, 6'd20, 1'b0, 1'b1, 6'd20, 1'b1, 3'd0,       // Same register
                    lanes(6'd20, 6'd20, 6'd20, 6'd12, 6'd41, 6'd19, 6'd21), 1'b0, 2'd1, 2'd1};
      tests[14] = '{1'b0, 6'd0, 1'b0, 1'b0, 6'd0, 1'b0, 3'd0,         // Repeated lookups
                    lanes(6'd3, 6'd3, 6'd12, 6'd12, 6'd20, 6'd20, 6'd5), 1'b0, 2'd0, 2'd0};
      tests[15] = '{1'b1, 6'd33, 1'b0, 1'b0, 6'd0, 1'b0, 3'd4,        // Long req hold
                    lanes(6'd33, 6'd33, 6'd32, 6'd34, 6'd0, 6'd1, 6'd2), 1'b0, 2'd1, 2'd0};
      tests[16] = '{1'b1, 6'd34, 1'b0, 1'b1, 6'd33, 1'b1, 3'd3,
                    lanes(6'd33, 6'd34, 6'd33, 6'd34, 6'd35, 6'd12, 6'd20), 1'b0, 2'd1, 2'd1};
      for (int k = 17; k < NUM_TESTS; k++) begin
         tests[k] = '{1'b1, 6'd0, 1'b0, 1'b1, 6'd0, 1'b1, 3'(k % 2), '0,  // Filled at run
                      1'b1, 2'd1, 2'd1};
      end
   endtask

   // Four-phase write on the allocation port
   task automatic alloc_write(input preg_t r, input logic v, input int hold);
      int n;
      alloc_wr  = '{preg: r, val: v};
      alloc_req = 1'b1;
      n = 0;
      do begin
         @(posedge CLK);
         #IN_DLY;
         n++;
      end while (!alloc_ack && n < HS_LIMIT);
      repeat (hold) begin
         @(posedge CLK);
         #IN_DLY;
      end
      alloc_req = 1'b0;
      n = 0;
      do begin
         @(posedge CLK);
         #IN_DLY;
         n++;
      end while (alloc_ack && n < HS_LIMIT);          // Next req only after ack is low
   endtask

   // Four-phase write on the writeback port
   task automatic wb_write(input preg_t r, input logic v, input int hold);
      int n;
      wb_wr  = '{preg: r, val: v};
      wb_req = 1'b1;
      n = 0;
      do begin
         @(posedge CLK);
         #IN_DLY;
         n++;
      end while (!wb_ack && n < HS_LIMIT);
      repeat (hold) begin
         @(posedge CLK);
         #IN_DLY;
      end
      wb_req = 1'b0;
      n = 0;
      do begin
         @(posedge CLK);
         #IN_DLY;
         n++;
      end while (wb_ack && n < HS_LIMIT);
   endtask

   task automatic apply_test(input test_t t);
      test_t cur;
      preg_t r;
      logic  b;
      cur = t;
      if (cur.rnd) begin
         for (int i = 0; i < NUM_RD; i++) begin
            take_reg(r);
            cur.rd[i] = r;
         end
         take_reg(r);
         cur.a_reg = r;
         take_bit(b);
         cur.a_val = b;
         take_reg(r);
         cur.w_reg = r;
         take_bit(b);
         cur.w_val = b;
      end
      rd_addr = cur.rd;                            // Held through the handshakes
      fork
         if (cur.a_en) alloc_write(cur.a_reg, cur.a_val, int'(cur.hold));
         if (cur.w_en) wb_write(cur.w_reg, cur.w_val, int'(cur.hold));
      join
      @(posedge CLK);
      #IN_DLY;
      exp_alloc = int'(cur.exp_a);
      exp_wb    = int'(cur.exp_w);
      test_end  = 1'b1;
      @(posedge CLK);
      #IN_DLY;
      test_end  = 1'b0;
   endtask

   initial begin
      lfsr      = SEED;
      arst_n    = 1'b0;
      alloc_req = 1'b0;
      alloc_wr  = '0;
      wb_req    = 1'b0;
      wb_wr     = '0;
      rd_addr   = '0;
      test_idx  = 0;
      test_end  = 1'b0;
      exp_alloc = 0;
      exp_wb    = 0;
      build_table();
      repeat (RST_CYCLES) @(posedge CLK);
      #IN_DLY;
      arst_n = 1'b1;
      wb_wr  = '{preg: 6'd47, val: 1'b1};          // Rename write raised during the sweep
      wb_req = 1'b1;                               // Must not be served before tbl_ready
      do begin
         @(posedge CLK);
         #IN_DLY;
      end while (!tbl_ready);                      // Init sweep runs about 4 cycles per entry
      wb_write(6'd47, 1'b1, 0);                    // Served once the arbiter leaves init
      for (int i = 0; i < NUM_TESTS; i++) begin
         test_idx = i;
         apply_test(tests[i]);
      end
      @(posedge CLK);
      #IN_DLY;
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
      if (err_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog sized from the sweep and the test count
   initial begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule
